//--- design/nic_consts.svh
// Shared widths, BAR0 register map and TLP field codes for the NIC endpoint
// Included by the package and by every module that needs a constant
`ifndef NIC_CONSTS_SVH
`define NIC_CONSTS_SVH

// --------------------
// Widths
// --------------------
`define TRN_DW         64      // trn data path
`define ADDR_W         64      // Host address
`define REG_OFF_W      5       // Dword offset, byte address bits [6:2]

// --------------------
// BAR0 register map
// --------------------
`define REG_PAGE1_LO   5'd0
`define REG_PAGE1_HI   5'd1
`define REG_PAGE2_LO   5'd2
`define REG_PAGE2_HI   5'd3
`define REG_INTR_EN    5'd4    // Bit 0 enables interrupts
`define REG_DOORBELL1  5'd5
`define REG_DOORBELL2  5'd6

// --------------------
// TLP fields
// --------------------
`define FMT_MWR_3DW    2'b10
`define FMT_MWR_4DW    2'b11
`define TYPE_MEM       5'b00000

`define REQ_FIFO_DEPTH 4       // Entries per request queue

`endif

//--- design/nic_pkg.sv
// Packed struct types passed between the NIC pipeline stages
// Modules name them scoped in port lists and import the package in the body
`include "nic_consts.svh"

package nic_pkg;

    // --------------------
    // Register write, decoder to bank
    // --------------------
    typedef struct packed {
        logic [`REG_OFF_W-1:0] offset;    // BAR0 dword offset
        logic [31:0]           data;      // Written dword
    } reg_wr_t;

    // --------------------
    // Notification, bank to builder
    // --------------------
    typedef struct packed {
        logic [`ADDR_W-1:0]    addr;      // Slot page address
        logic [31:0]           data;      // Doorbell value
        logic                  intr;      // Interrupt wanted after eof
    } notify_req_t;

    // --------------------
    // One trn beat
    // --------------------
    typedef struct packed {
        logic [`TRN_DW-1:0]    data;
        logic [7:0]            rem_n;     // All zero for full beats
        logic                  sof_n;
        logic                  eof_n;
    } trn_beat_t;

endpackage

//--- design/req_fifo.sv
// Show-ahead request queue shared by both pipeline hops
// The payload type is a parameter; pushes into a full queue are dropped
`timescale 1ns/1ps
`include "nic_consts.svh"

module req_fifo #(
    parameter type payload_t = logic,
    parameter int  depth     = `REQ_FIFO_DEPTH
) (
    input  logic     trn_clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty,
    output logic     full
);
    localparam int PTR_W = (depth > 1) ? $clog2(depth) : 1;
    localparam int CNT_W = $clog2(depth + 1);

    payload_t         mem [depth];       // Entry storage
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;             // Occupancy
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(depth - 1)) ? '0 : ptr + 1'b1;    // Wrap at depth
    endfunction

    assign empty    = (count == '0);
    assign full     = (count == CNT_W'(depth));
    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign pop_data = mem[rd_ptr];       // Head visible without a pop

    always_ff @(posedge trn_clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= ptr_inc(wr_ptr);
            if (do_pop)  rd_ptr <= ptr_inc(rd_ptr);
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    always_ff @(posedge trn_clk) begin
        if (do_push) mem[wr_ptr] <= push_data;
    end

endmodule

//--- design/tlp_rx_decoder.sv
// Watches the trn receive link and turns BAR0 single-dword writes into register writes
// Anything else is parsed past and ignored
`timescale 1ns/1ps
`include "nic_consts.svh"

module tlp_rx_decoder (
    input  logic               trn_clk,
    input  logic               rst_n,
    input  logic [`TRN_DW-1:0] trn_rd,
    input  logic [7:0]         trn_rrem,
    input  logic               trn_rsof_n,
    input  logic               trn_reof_n,
    input  logic               trn_rsrc_rdy_n,
    input  logic [6:0]         trn_rbar_hit_n,
    output logic               wr_push,
    output nic_pkg::reg_wr_t   wr_req
);
    import nic_pkg::*;

    typedef enum logic {ST_HDR, ST_DATA} rx_state_t;

    rx_state_t state;
    logic      hdr_ok;       // Header beat passed every check
    logic      beat_vld;     // Beat on the link this cycle
    logic      hdr_match;    // Checks on the current sof beat
    logic      data_eof;     // Second beat of a pending TLP

    assign beat_vld = !trn_rsrc_rdy_n;    // Top always listens

    // DW0 sits in the upper half of the header beat
    assign hdr_match = (trn_rd[62:61] == `FMT_MWR_3DW)
                    && (trn_rd[60:56] == `TYPE_MEM)
                    && (trn_rd[41:32] == 10'd1)        // Length field
                    && !trn_rbar_hit_n[0];             // BAR0, active low

    assign data_eof = beat_vld && trn_rsof_n && !trn_reof_n && (state == ST_DATA);

    // --------------------
    // Parser
    // --------------------
    always_ff @(posedge trn_clk) begin
        if (!rst_n) begin
            state   <= ST_HDR;
            hdr_ok  <= 1'b0;
            wr_push <= 1'b0;
        end else begin
            wr_push <= 1'b0;                           // One-cycle strobe
            if (beat_vld) begin
                if (!trn_rsof_n) begin
                    // A sof always restarts the parse
                    state  <= trn_reof_n ? ST_DATA : ST_HDR;
                    hdr_ok <= hdr_match;
                end else if (state == ST_DATA) begin
                    if (!trn_reof_n) begin
                        state   <= ST_HDR;
                        wr_push <= hdr_ok && (trn_rrem == 8'h00);
                    end else begin
                        hdr_ok <= 1'b0;                // More than two beats
                    end
                end
            end
        end
    end

    // --------------------
    // Payload capture
    // --------------------
    always_ff @(posedge trn_clk) begin
        if (data_eof) begin
            wr_req.offset <= trn_rd[34 +: `REG_OFF_W];   // Address bits [6:2]
            wr_req.data   <= trn_rd[31:0];               // Lower dword
        end
    end

endmodule

//--- design/host_register_bank.sv
// BAR0 register bank: two huge-page addresses, interrupt enable and two doorbells
// Applies queued writes in order and turns doorbells into notification requests
`timescale 1ns/1ps
`include "nic_consts.svh"

module host_register_bank (
    input  logic                 trn_clk,
    input  logic                 rst_n,
    // Register writes from the decoder queue
    input  logic                 wr_empty,
    input  nic_pkg::reg_wr_t     wr_req,
    output logic                 wr_pop,
    // Notification queue towards the builder
    input  logic                 notify_full,
    output logic                 notify_push,
    output nic_pkg::notify_req_t notify_req
);
    import nic_pkg::*;

    logic [`ADDR_W-1:0] page_addr_1;     // Slot 1 huge page
    logic [`ADDR_W-1:0] page_addr_2;     // Slot 2 huge page
    logic               intr_en;
    logic               is_doorbell;     // Head write hits a doorbell
    logic               is_slot1;

    assign is_slot1    = (wr_req.offset == `REG_DOORBELL1);
    assign is_doorbell = is_slot1 || (wr_req.offset == `REG_DOORBELL2);

    // --------------------
    // Pop control
    // --------------------
    // A doorbell stays at the head until the notification queue has room
    assign wr_pop      = !wr_empty && !(is_doorbell && notify_full);
    assign notify_push = wr_pop && is_doorbell;    // Same edge as the pop

    always_comb begin
        notify_req.addr = is_slot1 ? page_addr_1 : page_addr_2;
        notify_req.data = wr_req.data;             // Doorbell value carried on
        notify_req.intr = intr_en;                 // Enable at doorbell time
    end

    // --------------------
    // Registers
    // --------------------
    always_ff @(posedge trn_clk) begin
        if (!rst_n) begin
            intr_en <= 1'b0;                       // Interrupts off after reset
        end else if (wr_pop && (wr_req.offset == `REG_INTR_EN)) begin
            intr_en <= wr_req.data[0];
        end
    end

    always_ff @(posedge trn_clk) begin
        if (wr_pop) begin
            case (wr_req.offset)
                `REG_PAGE1_LO: page_addr_1[31:0]  <= wr_req.data;
                `REG_PAGE1_HI: page_addr_1[63:32] <= wr_req.data;
                `REG_PAGE2_LO: page_addr_2[31:0]  <= wr_req.data;
                `REG_PAGE2_HI: page_addr_2[63:32] <= wr_req.data;
                default: ;                         // Doorbells and enable handled above
            endcase
        end
    end

endmodule

//--- design/tlp_tx_builder.sv
// Sends one 64-bit-address memory-write notification per request on the trn tx link
// Raises a legacy interrupt after the eof beat when the request asks for one
`timescale 1ns/1ps
`include "nic_consts.svh"

module tlp_tx_builder (
    input  logic                 trn_clk,
    input  logic                 rst_n,
    input  logic [7:0]           cfg_bus_number,
    input  logic [4:0]           cfg_device_number,
    input  logic [2:0]           cfg_function_number,
    input  logic                 notify_empty,
    input  nic_pkg::notify_req_t notify_req,
    output logic                 notify_pop,
    input  logic [3:0]           trn_tbuf_av,
    input  logic                 trn_tdst_rdy_n,
    output nic_pkg::trn_beat_t   tx_beat,
    output logic                 trn_tsrc_rdy_n,
    input  logic                 cfg_interrupt_rdy_n,
    output logic                 cfg_interrupt_n
);
    import nic_pkg::*;

    typedef enum logic [2:0] {ST_IDLE, ST_BEAT0, ST_BEAT1, ST_BEAT2, ST_INTR} tx_state_t;

    tx_state_t          state;
    notify_req_t        cur_req;         // Request on the wire
    logic [31:0]        seq_cnt;         // Notifications sent since reset
    logic [`TRN_DW-1:0] beat_data;
    logic [`TRN_DW-1:0] next_data;
    logic               sof_n;
    logic               eof_n;
    logic               start;
    logic               xfer;            // Beat accepted this cycle
    logic               load;
    logic [31:0]        dw0;
    logic [31:0]        dw1;

    // fmt, type, TC, TD, EP, attr, length 2
    assign dw0 = {1'b0, `FMT_MWR_4DW, `TYPE_MEM, 1'b0, 3'b000, 4'b0000,
                  1'b0, 1'b0, 2'b00, 2'b00, 10'd2};
    // Requester ID, tag 0, last and first BE all ones
    assign dw1 = {cfg_bus_number, cfg_device_number, cfg_function_number, 8'h00, 4'hf, 4'hf};

    assign start      = (state == ST_IDLE) && !notify_empty && trn_tbuf_av[1];
    assign xfer       = !trn_tsrc_rdy_n && !trn_tdst_rdy_n;
    assign notify_pop = start;
    assign load       = start || (xfer && (state == ST_BEAT0 || state == ST_BEAT1));

    always_comb begin
        case (state)
            ST_BEAT0: next_data = cur_req.addr;                 // Upper then lower half
            ST_BEAT1: next_data = {cur_req.data, seq_cnt};
            default:  next_data = {dw0, dw1};                   // Header beat
        endcase
    end

    // --------------------
    // FSM and handshakes
    // --------------------
    always_ff @(posedge trn_clk) begin
        if (!rst_n) begin
            state           <= ST_IDLE;
            trn_tsrc_rdy_n  <= 1'b1;
            sof_n           <= 1'b1;
            eof_n           <= 1'b1;
            cfg_interrupt_n <= 1'b1;
            seq_cnt         <= '0;
        end else begin
            case (state)
                ST_IDLE: if (start) begin
                    state          <= ST_BEAT0;
                    trn_tsrc_rdy_n <= 1'b0;
                    sof_n          <= 1'b0;
                end
                ST_BEAT0: if (xfer) begin
                    state <= ST_BEAT1;
                    sof_n <= 1'b1;
                end
                ST_BEAT1: if (xfer) begin
                    state <= ST_BEAT2;
                    eof_n <= 1'b0;
                end
                ST_BEAT2: if (xfer) begin                       // eof transferred
                    trn_tsrc_rdy_n  <= 1'b1;
                    eof_n           <= 1'b1;
                    seq_cnt         <= seq_cnt + 1'b1;
                    state           <= cur_req.intr ? ST_INTR : ST_IDLE;
                    cfg_interrupt_n <= !cur_req.intr;
                end
                ST_INTR: if (!cfg_interrupt_rdy_n) begin         // Held until ready seen
                    cfg_interrupt_n <= 1'b1;
                    state           <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge trn_clk) begin
        if (start) cur_req <= notify_req;
        if (load)  beat_data <= next_data;                      // Holds under back-pressure
    end

    assign tx_beat.data  = beat_data;
    assign tx_beat.rem_n = 8'h00;                               // Full beats only
    assign tx_beat.sof_n = sof_n;
    assign tx_beat.eof_n = eof_n;

endmodule

//--- design/nic_pcie_app.sv
// PCIe endpoint application top: rx decoder, register bank and notification builder
// Connects the stages through two request queues and drives the trn tx pins
`timescale 1ns/1ps
`include "nic_consts.svh"

module nic_pcie_app (
    input  logic               trn_clk,
    input  logic               rst_n,
    // Rx local-link
    input  logic [`TRN_DW-1:0] trn_rd,
    input  logic [7:0]         trn_rrem,
    input  logic               trn_rsof_n,
    input  logic               trn_reof_n,
    input  logic               trn_rsrc_rdy_n,
    input  logic [6:0]         trn_rbar_hit_n,
    output logic               trn_rdst_rdy_n,
    // Tx local-link
    output logic [`TRN_DW-1:0] trn_td,
    output logic [7:0]         trn_trem_n,
    output logic               trn_tsof_n,
    output logic               trn_teof_n,
    output logic               trn_tsrc_rdy_n,
    input  logic               trn_tdst_rdy_n,
    input  logic [3:0]         trn_tbuf_av,
    // Configuration
    input  logic [7:0]         cfg_bus_number,
    input  logic [4:0]         cfg_device_number,
    input  logic [2:0]         cfg_function_number,
    output logic               cfg_interrupt_n,
    input  logic               cfg_interrupt_rdy_n
);
    import nic_pkg::*;

    // --------------------
    // Stage links
    // --------------------
    logic        wr_push;
    reg_wr_t     wr_req;
    reg_wr_t     wr_head;          // Queue output to the bank
    logic        wr_pop;
    logic        wr_empty;
    logic        notify_push;
    notify_req_t notify_req;
    notify_req_t notify_head;
    logic        notify_pop;
    logic        notify_empty;
    logic        notify_full;
    trn_beat_t   tx_beat;

    assign trn_rdst_rdy_n = 1'b0;  // Always listen

    tlp_rx_decoder u_tlp_rx_decoder (
        .trn_clk, .rst_n, .trn_rd, .trn_rrem, .trn_rsof_n, .trn_reof_n,
        .trn_rsrc_rdy_n, .trn_rbar_hit_n, .wr_push, .wr_req
    );

    req_fifo #(.payload_t(reg_wr_t)) u_wr_fifo (
        .trn_clk, .rst_n, .push(wr_push), .push_data(wr_req), .pop(wr_pop),
        .pop_data(wr_head), .empty(wr_empty), .full()    // Full drops writes
    );

    host_register_bank u_host_register_bank (
        .trn_clk, .rst_n, .wr_empty, .wr_req(wr_head), .wr_pop,
        .notify_full, .notify_push, .notify_req
    );

    req_fifo #(.payload_t(notify_req_t)) u_notify_fifo (
        .trn_clk, .rst_n, .push(notify_push), .push_data(notify_req), .pop(notify_pop),
        .pop_data(notify_head), .empty(notify_empty), .full(notify_full)
    );

    tlp_tx_builder u_tlp_tx_builder (
        .trn_clk, .rst_n, .cfg_bus_number, .cfg_device_number, .cfg_function_number,
        .notify_empty, .notify_req(notify_head), .notify_pop, .trn_tbuf_av,
        .trn_tdst_rdy_n, .tx_beat, .trn_tsrc_rdy_n, .cfg_interrupt_rdy_n, .cfg_interrupt_n
    );

    // Beat struct onto the trn pins
    assign trn_td     = tx_beat.data;
    assign trn_trem_n = tx_beat.rem_n;
    assign trn_tsof_n = tx_beat.sof_n;
    assign trn_teof_n = tx_beat.eof_n;

endmodule

//--- bench/nic_pcie_app_asserts.sv
// Concurrent checks on the trn tx and legacy interrupt handshakes
// Bound onto the NIC top from the testbench
`timescale 1ns/1ps
`include "nic_consts.svh"

module nic_pcie_app_asserts (
    input logic               trn_clk,
    input logic               rst_n,
    input logic [`TRN_DW-1:0] trn_td,
    input logic [7:0]         trn_trem_n,
    input logic               trn_tsof_n,
    input logic               trn_teof_n,
    input logic               trn_tsrc_rdy_n,
    input logic               trn_tdst_rdy_n,
    input logic               cfg_interrupt_n,
    input logic               cfg_interrupt_rdy_n
);

    // Stalled beat must hold
    assert property (@(posedge trn_clk) disable iff (!rst_n)
        (!trn_tsrc_rdy_n && trn_tdst_rdy_n) |=>
            (!trn_tsrc_rdy_n && $stable({trn_td, trn_trem_n, trn_tsof_n, trn_teof_n})))
        else $error("tx beat changed while stalled");

    // Interrupt request held until ready
    assert property (@(posedge trn_clk) disable iff (!rst_n)
        (!cfg_interrupt_n && cfg_interrupt_rdy_n) |=> !cfg_interrupt_n)
        else $error("cfg_interrupt_n released before cfg_interrupt_rdy_n");

    // Three-beat TLPs only
    assert property (@(posedge trn_clk) disable iff (!rst_n)
        !trn_tsrc_rdy_n |-> !(!trn_tsof_n && !trn_teof_n))
        else $error("tx beat with both sof and eof");

endmodule

//--- bench/nic_pcie_app_tb.sv
// Testbench for the NIC PCIe application with table-driven rx writes and tx and interrupt checks
// Holds a model of the register bank that predicts each notification beat
`timescale 1ns/1ps
`include "nic_consts.svh"

module nic_pcie_app_tb;
    import nic_pkg::*;

    localparam int K_WR = 0, K_BAR_MISS = 1, K_FMT_4DW = 2, K_FMT_RD = 3, K_LEN2 = 4, K_REM = 5;
    localparam logic [7:0] BUS = 8'h3c;
    localparam logic [4:0] DEV = 5'h07;
    localparam logic [2:0] FUNC = 3'h2;

    logic clk = 1'b0;
    logic rst_n = 1'b0;
    logic [63:0] trn_rd = '0;
    logic [7:0] trn_rrem = '0;
    logic trn_rsof_n = 1'b1, trn_reof_n = 1'b1, trn_rsrc_rdy_n = 1'b1;
    logic [6:0] trn_rbar_hit_n = 7'h7f;
    logic trn_rdst_rdy_n;
    logic [63:0] trn_td;
    logic [7:0] trn_trem_n;
    logic trn_tsof_n, trn_teof_n, trn_tsrc_rdy_n;
    logic trn_tdst_rdy_n = 1'b1;
    logic [3:0] trn_tbuf_av = 4'hf;
    logic cfg_interrupt_n;
    logic cfg_interrupt_rdy_n = 1'b1;

    // --------------------
    // Stimulus table
    // --------------------
    string t_name[$];
    int t_kind[$], t_hold[$];
    logic [4:0] t_off[$];
    logic [31:0] t_data[$];
    bit t_wait[$], t_bp[$];

    // Model state
    logic [63:0] m_page1 = '0, m_page2 = '0;
    logic m_intr_en = 1'b0;
    logic [31:0] m_seq = '0;
    trn_beat_t exp_beats[$];
    bit exp_intr[$];
    bit intr_exp = 1'b0;          // Interrupt line expected low
    bit cur_intr = 1'b0;          // Flag of notification on the wire
    bit bp_en = 1'b0;
    string cur_name = "reset";
    int cycles = 0, timeout_limit = 1000000, icnt = 0;
    logic prev_tsrc_n = 1'b1, prev_tbuf1 = 1'b1;

    nic_pcie_app u_nic_pcie_app (
        .trn_clk(clk), .rst_n, .trn_rd, .trn_rrem, .trn_rsof_n, .trn_reof_n,
        .trn_rsrc_rdy_n, .trn_rbar_hit_n, .trn_rdst_rdy_n, .trn_td, .trn_trem_n,
        .trn_tsof_n, .trn_teof_n, .trn_tsrc_rdy_n, .trn_tdst_rdy_n, .trn_tbuf_av,
        .cfg_bus_number(BUS), .cfg_device_number(DEV), .cfg_function_number(FUNC),
        .cfg_interrupt_n, .cfg_interrupt_rdy_n
    );

    bind nic_pcie_app nic_pcie_app_asserts u_asserts (.*);

    initial begin
        forever #5 clk = ~clk;
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_beat(input string name, input trn_beat_t exp, input trn_beat_t act);
        if (exp !== act)
            stop_run($sformatf("mismatch %s: expected %h actual %h", name, exp, act));
    endtask

    task automatic check_intr(input string name, input logic exp, input logic act);
        if (exp !== act)
            stop_run($sformatf("mismatch %s cfg_interrupt_n: expected %b actual %b",
                               name, exp, act));
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        if (exp !== act)
            stop_run($sformatf("mismatch %s: expected %b actual %b", name, exp, act));
    endtask

    task automatic add_test(input string name, input int kind, input logic [4:0] off,
                            input logic [31:0] data, input bit wt, input bit bp, input int hold);
        t_name.push_back(name);
        t_kind.push_back(kind);
        t_off.push_back(off);
        t_data.push_back(data);
        t_wait.push_back(wt);
        t_bp.push_back(bp);
        t_hold.push_back(hold);
    endtask

    // Expected beats and interrupt flag of one notification
    task automatic expect_notify(input logic [63:0] addr, input logic [31:0] data);
        logic [31:0] dw0;
        logic [31:0] dw1;
        dw0 = {1'b0, `FMT_MWR_4DW, `TYPE_MEM, 14'b0, 10'd2};
        dw1 = {BUS, DEV, FUNC, 8'h00, 8'hff};
        exp_beats.push_back('{data: {dw0, dw1}, rem_n: 8'h00, sof_n: 1'b0, eof_n: 1'b1});
        exp_beats.push_back('{data: addr, rem_n: 8'h00, sof_n: 1'b1, eof_n: 1'b1});
        exp_beats.push_back('{data: {data, m_seq}, rem_n: 8'h00, sof_n: 1'b1, eof_n: 1'b0});
        exp_intr.push_back(m_intr_en);
        m_seq = m_seq + 1;
    endtask

    task automatic model_write(input logic [4:0] off, input logic [31:0] data);
        case (off)
            `REG_PAGE1_LO: m_page1[31:0] = data;
            `REG_PAGE1_HI: m_page1[63:32] = data;
            `REG_PAGE2_LO: m_page2[31:0] = data;
            `REG_PAGE2_HI: m_page2[63:32] = data;
            `REG_INTR_EN: m_intr_en = data[0];
            `REG_DOORBELL1: expect_notify(m_page1, data);
            `REG_DOORBELL2: expect_notify(m_page2, data);
            default: ;
        endcase
    endtask

    // Sends a two-beat write TLP or one of its malformed variants
    task automatic send_tlp(input int kind, input logic [4:0] off, input logic [31:0] data);
        logic [1:0] fmt;
        logic [9:0] len;
        logic [7:0] rem;
        logic [6:0] hit;
        fmt = `FMT_MWR_3DW;
        len = 10'd1;
        rem = 8'h00;
        hit = 7'h7e;
        case (kind)
            K_BAR_MISS: hit = 7'h7d;
            K_FMT_4DW: fmt = `FMT_MWR_4DW;
            K_FMT_RD: fmt = 2'b00;
            K_LEN2: len = 10'd2;
            K_REM: rem = 8'h0f;
            default: ;
        endcase
        @(posedge clk);
        trn_rd <= {1'b0, fmt, `TYPE_MEM, 14'b0, len, 32'h0000_000f};
        trn_rsof_n <= 1'b0;
        trn_reof_n <= 1'b1;
        trn_rrem <= 8'h00;
        trn_rsrc_rdy_n <= 1'b0;
        trn_rbar_hit_n <= hit;
        @(posedge clk);
        trn_rd <= {25'b0, off, 2'b00, data};       // Address dword then data dword
        trn_rsof_n <= 1'b1;
        trn_reof_n <= 1'b0;
        trn_rrem <= rem;
        @(posedge clk);
        trn_rsrc_rdy_n <= 1'b1;
        trn_reof_n <= 1'b1;
        trn_rbar_hit_n <= 7'h7f;
        if (kind == K_WR) model_write(off, data);
    endtask

    task automatic wait_idle();
        while (exp_beats.size() != 0 || intr_exp || !trn_tsrc_rdy_n) @(negedge clk);
    endtask

    // --------------------
    // Responders and monitor
    // --------------------
    always @(posedge clk) begin
        trn_tdst_rdy_n <= bp_en ? ($urandom % 3 == 0) : 1'b0;    // Random stalls
        cycles <= cycles + 1;
        if (cycles > timeout_limit) stop_run("timeout: DUT did not finish in time");
    end

    always @(posedge clk) begin
        if (!rst_n || cfg_interrupt_n || !cfg_interrupt_rdy_n) begin
            cfg_interrupt_rdy_n <= 1'b1;
            icnt <= 0;
        end else begin
            icnt <= icnt + 1;
            if (icnt == 3) cfg_interrupt_rdy_n <= 1'b0;    // Late ready
        end
    end

    always @(negedge clk) begin
        check_intr(cur_name, !intr_exp, cfg_interrupt_n);
        check_level({cur_name, " trn_rdst_rdy_n"}, 1'b0, trn_rdst_rdy_n);
        if (!rst_n) begin
            check_level("reset trn_tsrc_rdy_n", 1'b1, trn_tsrc_rdy_n);
        end else begin
            if (!trn_tsrc_rdy_n && prev_tsrc_n && !prev_tbuf1)
                stop_run({cur_name, ": TLP started while posted buffer flag was low"});
            if (!trn_tsrc_rdy_n && !trn_tdst_rdy_n) begin
                if (exp_beats.size() == 0)
                    stop_run({cur_name, ": unexpected beat on the tx link"});
                if (!exp_beats[0].sof_n) cur_intr = exp_intr.pop_front();
                check_beat(cur_name, exp_beats.pop_front(),
                           '{data: trn_td, rem_n: trn_trem_n, sof_n: trn_tsof_n,
                             eof_n: trn_teof_n});
                if (!trn_teof_n && cur_intr) intr_exp = 1'b1;
            end
            if (intr_exp && !cfg_interrupt_n && !cfg_interrupt_rdy_n) intr_exp = 1'b0;
        end
        prev_tsrc_n = trn_tsrc_rdy_n;
        prev_tbuf1 = trn_tbuf_av[1];
    end

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        void'($urandom(32'hbdd1_e129));
        add_test("page1_lo", K_WR, `REG_PAGE1_LO, 32'h1000_0000, 0, 0, 0);
        add_test("page1_hi", K_WR, `REG_PAGE1_HI, 32'h0000_00a5, 0, 0, 0);
        add_test("page2_lo", K_WR, `REG_PAGE2_LO, 32'h2000_0000, 0, 0, 0);
        add_test("page2_hi", K_WR, `REG_PAGE2_HI, 32'h0000_00b6, 0, 0, 0);
        add_test("doorbell1", K_WR, `REG_DOORBELL1, 32'hdead_0001, 1, 0, 0);
        add_test("doorbell2", K_WR, `REG_DOORBELL2, 32'hdead_0002, 1, 0, 0);
        add_test("bar_miss", K_BAR_MISS, `REG_PAGE1_LO, 32'h3333_0000, 0, 0, 0);
        add_test("fmt_4dw", K_FMT_4DW, `REG_PAGE1_LO, 32'h4444_0000, 0, 0, 0);
        add_test("fmt_read", K_FMT_RD, `REG_PAGE1_LO, 32'h5555_0000, 0, 0, 0);
        add_test("length_2", K_LEN2, `REG_PAGE1_LO, 32'h6666_0000, 0, 0, 0);
        add_test("rrem_nonzero", K_REM, `REG_PAGE1_LO, 32'h7777_0000, 0, 0, 0);
        add_test("doorbell1_after_bad", K_WR, `REG_DOORBELL1, 32'hbeef_0003, 1, 0, 0);
        add_test("intr_on", K_WR, `REG_INTR_EN, 32'h0000_0001, 0, 0, 0);
        add_test("doorbell1_intr", K_WR, `REG_DOORBELL1, 32'hcafe_0004, 1, 0, 0);
        add_test("doorbell2_intr", K_WR, `REG_DOORBELL2, 32'hcafe_0005, 1, 0, 0);
        add_test("doorbell1_bp_buf", K_WR, `REG_DOORBELL1, 32'hf00d_0006, 1, 1, 20);
        add_test("doorbell2_bp", K_WR, `REG_DOORBELL2, 32'hf00d_0007, 1, 1, 0);
        add_test("intr_off", K_WR, `REG_INTR_EN, 32'h0000_0000, 0, 0, 0);
        add_test("burst_1", K_WR, `REG_DOORBELL1, 32'h0b00_0001, 0, 1, 0);
        add_test("burst_2", K_WR, `REG_DOORBELL2, 32'h0b00_0002, 0, 1, 0);
        add_test("burst_3", K_WR, `REG_DOORBELL1, 32'h0b00_0003, 0, 1, 0);
        add_test("burst_4", K_WR, `REG_DOORBELL2, 32'h0b00_0004, 1, 1, 0);
        add_test("doorbell2_final", K_WR, `REG_DOORBELL2, 32'h0e0d_0005, 1, 0, 0);
        timeout_limit = t_name.size() * 60 + 16;

        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        cur_name = "after_reset";
        @(posedge clk);
        check_level("after reset trn_tsrc_rdy_n", 1'b1, trn_tsrc_rdy_n);

        for (int i = 0; i < t_name.size(); i++) begin
            cur_name = t_name[i];
            bp_en <= t_bp[i];
            if (t_hold[i] > 0) begin
                @(posedge clk);
                trn_tbuf_av <= 4'b0101;    // Posted buffers exhausted
            end
            send_tlp(t_kind[i], t_off[i], t_data[i]);
            if (t_hold[i] > 0) begin
                repeat (t_hold[i]) @(posedge clk);
                trn_tbuf_av <= 4'hf;
            end
            if (t_wait[i]) wait_idle();
        end
        bp_en = 1'b0;
        wait_idle();
        repeat (10) @(posedge clk);
        if (exp_beats.size() != 0 || exp_intr.size() != 0 || intr_exp) begin
            $display("notifications missing at end of run");
            $display("test failed");
            $fatal(1, "run stopped");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

//--- flist.f
+incdir+design
design/nic_pkg.sv
design/req_fifo.sv
design/tlp_rx_decoder.sv
design/host_register_bank.sv
design/tlp_tx_builder.sv
design/nic_pcie_app.sv
bench/nic_pcie_app_asserts.sv
bench/nic_pcie_app_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and judge the result from the simulation log
rm -f sim.log
verilator --binary --timing --assert -f flist.f --top-module nic_pcie_app_tb -o nic_sim \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/nic_sim > sim.log 2>&1 || true
grep -qx "test passed" sim.log && echo "PASS" || { cat sim.log; echo "FAIL"; exit 1; }
